// File: ecfg_node.f
verilog/ecfg_pkg.sv
verilog/ecfg_decode.sv
verilog/ecfg_regs.sv
verilog/emmu_table.sv
verilog/ecfg_response.sv
verilog/ecfg_node.sv
testbench/tb_ecfg_node.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_ecfg_node -f ecfg_node.f \
   && ./obj_dir/Vtb_ecfg_node 2>&1 | tee /dev/stderr | grep "^Verification passed$" > /dev/null \
   && echo "simulation ok" \
   || { echo "simulation not ok"; exit 1; }

// File: testbench/tb_ecfg_node.sv
`timescale 1ns/1ps

module tb_ecfg_node
   import ecfg_pkg::*;
();

   // stimulus and expected output of one cycle
   typedef struct packed {
      logic    access;
      packet_t pkt;
      logic    wt;
      logic    exp_access;
      packet_t exp_pkt;
   } row_t;

   logic        clk = 1'b0;
   logic        reset;
   logic        access_in;
   packet_t     packet_in;
   logic        wait_in;
   logic        access_out;
   packet_t     packet_out;
   logic        wait_out;
   logic [31:0] lcg_state = 32'h8d47;
   row_t        table_q[$];
   // expected register contents
   mi_data_t    cfg_model [cfg_regs];
   mi_data_t    mmu_model [mmu_entries];

   ecfg_node #(.rx_side(1'b0)) i_dut (
      .clk(clk), .reset(reset), .access_in(access_in), .packet_in(packet_in),
      .wait_in(wait_in), .access_out(access_out), .packet_out(packet_out),
      .wait_out(wait_out));

   // 10 ns clock
   initial
   begin
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // srcaddr on top, bit 7 zero
   function automatic packet_t make_packet(logic wr, logic [31:0] dst, logic [31:0] dat,
                                           logic [31:0] src, logic [1:0] dm, logic [3:0] cm);
      return {src, dat, dst, 1'b0, cm, dm, wr};
   endfunction

   task automatic push_row(logic acc, packet_t pkt, logic wt, logic exp_acc, packet_t exp_pkt);
      table_q.push_back(row_t'({acc, pkt, wt, exp_acc, exp_pkt}));
   endtask

   // register write or read row, a write gives no output
   task automatic reg_access(logic is_mmu, logic we, logic [3:0] idx);
      logic [31:0] src;
      logic [31:0] dat;
      logic [31:0] dst;
      mi_data_t    value;
      src = next_rand();
      dat = next_rand();
      // mmu index at bits 6:3, config select 01 and side 0 with index at bits 4:3
      dst = is_mmu ? {chip_id, 4'hE, 9'd0, idx, 3'd0}
                   : {chip_id, 4'hF, 5'd0, 2'b01, 1'b0, 3'd0, idx[1:0], 3'd0};
      value = is_mmu ? mmu_model[idx] : cfg_model[idx[1:0]];
      if (we && is_mmu)
         mmu_model[idx] = {src, dat};
      else if (we)
         cfg_model[idx[1:0]] = {src, dat};
      // response goes back to srcaddr, stored word split over srcaddr and data
      push_row(1'b1, make_packet(we, dst, dat, src, src[1:0], src[5:2]), 1'b0, !we,
               make_packet(1'b1, src, value[31:0], value[63:32], src[1:0], src[5:2]));
   endtask

   task automatic check_access(string name, logic got, logic exp);
      if (got !== exp)
      begin
         $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
         $display("Verification failed");
         $fatal(1);
      end
   endtask

   task automatic check_packet(packet_t got, packet_t exp);
      string   names [7] = '{"write", "datamode", "ctrlmode", "reserved", "dstaddr",
                             "data", "srcaddr"};
      int      lsbs [7] = '{write_bit, datamode_lsb, ctrlmode_lsb, rsvd_bit, dstaddr_lsb,
                            data_lsb, srcaddr_lsb};
      int      widths [7] = '{1, 2, 4, 1, 32, 32, 32};
      packet_t mask;
      for (int f = 0; f < 7; f++)
      begin
         mask = ((packet_t'(1) << widths[f]) - packet_t'(1)) << lsbs[f];
         if ((got & mask) !== (exp & mask))
         begin
            $display("ERROR packet_out.%s got 0x%h expected 0x%h", names[f],
                     32'((got & mask) >> lsbs[f]), 32'((exp & mask) >> lsbs[f]));
            $display("Verification failed");
            $fatal(1);
         end
      end
   endtask

   initial
   begin
      packet_t pkt;
      reset     <= 1'b1;
      access_in <= 1'b0;
      packet_in <= '0;
      wait_in   <= 1'b0;
      cfg_model = '{default: '0};
      mmu_model = '{default: '0};
      // reads straight after reset see zero everywhere
      push_row(1'b0, '0, 1'b0, 1'b0, '0);
      for (int i = 0; i < cfg_regs; i++)
         reg_access(1'b0, 1'b0, 4'(i));
      reg_access(1'b1, 1'b0, 4'd9);
      // config write then read back
      reg_access(1'b0, 1'b1, 4'd1);
      reg_access(1'b0, 1'b0, 4'd1);
      reg_access(1'b0, 1'b1, 4'd3);
      reg_access(1'b0, 1'b0, 4'd3);
      // mmu entries read back out of order, entry 7 never written
      reg_access(1'b1, 1'b1, 4'd2);
      reg_access(1'b1, 1'b1, 4'd5);
      reg_access(1'b1, 1'b1, 4'd11);
      reg_access(1'b1, 1'b0, 4'd11);
      reg_access(1'b1, 1'b0, 4'd2);
      reg_access(1'b1, 1'b0, 4'd7);
      reg_access(1'b1, 1'b0, 4'd5);
      // group E with bit 15 set belongs to the other side
      pkt = make_packet(1'b0, {chip_id, 4'hE, 16'h8010}, next_rand(), next_rand(), 2'b10, 4'h3);
      push_row(1'b1, pkt, 1'b0, 1'b1, pkt);
      // group F slot with no register here
      pkt = make_packet(1'b1, {chip_id, 4'hF, 16'h0008}, next_rand(), next_rand(), 2'b01, 4'h5);
      push_row(1'b1, pkt, 1'b0, 1'b1, pkt);
      // write meant for another node, config 1 must keep its value
      pkt = make_packet(1'b1, {12'h811, 4'hF, 16'h0208}, next_rand(), next_rand(), 2'b00, 4'h0);
      push_row(1'b1, pkt, 1'b0, 1'b0, '0);
      reg_access(1'b0, 1'b0, 4'd1);
      // three stalled rows, write to config 1 held at the input
      pkt = make_packet(1'b1, {chip_id, 4'hF, 16'h0208}, next_rand(), next_rand(), 2'b11, 4'h0);
      repeat (3)
         push_row(1'b1, pkt, 1'b1, table_q[$].exp_access, table_q[$].exp_pkt);
      reg_access(1'b0, 1'b0, 4'd1);
      // padding so the last real row gets checked
      push_row(1'b0, '0, 1'b0, 1'b0, '0);
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      check_access("access_out", access_out, 1'b0);
      for (int i = 0; i < table_q.size(); i++)
      begin
         @(posedge clk);
         access_in <= table_q[i].access;
         packet_in <= table_q[i].pkt;
         wait_in   <= table_q[i].wt;
         // outputs show the previous row here
         @(negedge clk);
         // stall passes straight through in the same cycle
         check_access("wait_out", wait_out, table_q[i].wt);
         if (i > 0)
            check_access("access_out", access_out, table_q[i-1].exp_access);
         if (i > 0 && table_q[i-1].exp_access)
            check_packet(packet_out, table_q[i-1].exp_pkt);
      end
      $display("Verification passed");
      $finish;
   end

   // table is filled at time zero, limit follows from its length
   initial
   begin
      #1;
      #(table_q.size() * 10 + 200);
      $display("run timed out before all rows were checked");
      $display("Verification failed");
      $fatal(1);
   end

endmodule

// File: verilog/ecfg_decode.sv
`timescale 1ns/1ps

module ecfg_decode
   import ecfg_pkg::*;
#(
   parameter logic rx_side = 1'b0
)
(
   input  logic         clk,
   input  logic         reset,
   input  logic         access_in,
   input  packet_t      packet_in,
   input  logic         wait_in,
   output space_e       mi_space,
   output logic         mi_we,
   output mi_addr_t     mi_addr,
   output mi_data_t     mi_din,
   output access_kind_e kind,
   output logic         write,
   output logic [1:0]   datamode,
   output logic [3:0]   ctrlmode,
   output logic [31:0]  dstaddr,
   output logic [31:0]  data,
   output logic [31:0]  srcaddr
);

   logic accept;
   logic match;
   logic grp_hit;
   logic cfg_hit;
   logic mmu_hit;
   logic reg_hit;

   // split the packet into its fields
   assign write    = packet_in[write_bit];
   assign datamode = packet_in[datamode_msb:datamode_lsb];
   assign ctrlmode = packet_in[ctrlmode_msb:ctrlmode_lsb];
   assign dstaddr  = packet_in[dstaddr_msb:dstaddr_lsb];
   assign data     = packet_in[data_msb:data_lsb];
   assign srcaddr  = packet_in[srcaddr_msb:srcaddr_lsb];

   // nothing is taken while the output side is stalled
   assign accept = access_in & ~wait_in;

   // packet addressed to this node
   assign match = accept & (dstaddr[31:20] == chip_id);

   // any register group, even when no space on this side matches
   assign grp_hit = match & ((dstaddr[19:16] == grp_cfg) | (dstaddr[19:16] == grp_mmu));

   // config bank, select code plus side bit
   assign cfg_hit = match
                  & (dstaddr[19:16] == grp_cfg)
                  & (dstaddr[10:9] == cfg_sel)
                  & (dstaddr[8] == rx_side);

   // mmu table, side given by bit 15
   assign mmu_hit = match
                  & (dstaddr[19:16] == grp_mmu)
                  & (dstaddr[15] == rx_side);

   assign reg_hit = cfg_hit | mmu_hit;

   // register interface
   assign mi_space = cfg_hit ? space_cfg : (mmu_hit ? space_mmu : space_none);
   assign mi_we    = write & reg_hit;
   assign mi_addr  = dstaddr[14:0];
   // upper half carried in srcaddr
   assign mi_din   = {srcaddr, data};

   // classify the access for the response stage
   always_comb
   begin
      if (reg_hit)
      begin
         kind = write ? kind_reg_write : kind_reg_read;
      end
      else if (grp_hit)
      begin
         // other side or unmapped slot in the group, pass it on
         kind = kind_forward;
      end
      else
      begin
         kind = kind_none;
      end
   end

endmodule

// File: verilog/ecfg_node.sv
`timescale 1ns/1ps

module ecfg_node
   import ecfg_pkg::*;
#(
   // 0 transmit side, 1 receive side
   parameter logic rx_side = 1'b0
)
(
   input  logic    clk,
   input  logic    reset,
   input  logic    access_in,
   input  packet_t packet_in,
   input  logic    wait_in,
   output logic    access_out,
   output packet_t packet_out,
   output logic    wait_out
);

   space_e       mi_space;
   logic         mi_we;
   mi_addr_t     mi_addr;
   mi_data_t     mi_din;
   mi_data_t     cfg_dout;
   mi_data_t     mmu_dout;
   mi_data_t     mi_dout;
   logic         cfg_en;
   logic         mmu_en;
   access_kind_e kind;
   logic         write;
   logic [1:0]   datamode;
   logic [3:0]   ctrlmode;
   logic [31:0]  dstaddr;
   logic [31:0]  data;
   logic [31:0]  srcaddr;

   // stall goes straight back upstream
   assign wait_out = wait_in;

   // one enable per register space
   assign cfg_en = (mi_space == space_cfg);
   assign mmu_en = (mi_space == space_mmu);

   // unselected blocks drive zero
   assign mi_dout = cfg_dout | mmu_dout;

   ecfg_decode #(.rx_side(rx_side)) i_decode (
      .clk(clk), .reset(reset), .access_in(access_in), .packet_in(packet_in),
      .wait_in(wait_in), .mi_space(mi_space), .mi_we(mi_we), .mi_addr(mi_addr),
      .mi_din(mi_din), .kind(kind), .write(write), .datamode(datamode),
      .ctrlmode(ctrlmode), .dstaddr(dstaddr), .data(data), .srcaddr(srcaddr));

   ecfg_regs i_regs (
      .clk(clk), .reset(reset), .mi_en(cfg_en), .mi_we(mi_we),
      .mi_addr(mi_addr), .mi_din(mi_din), .dout(cfg_dout));

   emmu_table i_mmu (
      .clk(clk), .reset(reset), .mi_en(mmu_en), .mi_we(mi_we),
      .mi_addr(mi_addr), .mi_din(mi_din), .dout(mmu_dout));

   ecfg_response i_response (
      .clk(clk), .reset(reset), .kind(kind), .write(write), .datamode(datamode),
      .ctrlmode(ctrlmode), .dstaddr(dstaddr), .data(data), .srcaddr(srcaddr),
      .mi_dout(mi_dout), .wait_in(wait_in), .access_out(access_out),
      .packet_out(packet_out));

endmodule

// File: verilog/ecfg_pkg.sv
package ecfg_pkg;

   // mesh packet, one 104-bit word
   localparam int pkt_w = 104;
   typedef logic [pkt_w-1:0] packet_t;

   // field positions inside the packet
   localparam int write_bit    = 0;
   localparam int datamode_lsb = 1;
   localparam int datamode_msb = 2;
   localparam int ctrlmode_lsb = 3;
   localparam int ctrlmode_msb = 6;
   // reserved, always sent as zero
   localparam int rsvd_bit     = 7;
   localparam int dstaddr_lsb  = 8;
   localparam int dstaddr_msb  = 39;
   localparam int data_lsb     = 40;
   localparam int data_msb     = 71;
   localparam int srcaddr_lsb  = 72;
   localparam int srcaddr_msb  = 103;

   // node identity, compared with dstaddr[31:20]
   localparam logic [11:0] chip_id = 12'h810;

   // group codes in dstaddr[19:16]
   localparam logic [3:0] grp_cfg = 4'hF;
   localparam logic [3:0] grp_mmu = 4'hE;

   // config select code in dstaddr[10:9], bit 8 picks the side
   localparam logic [1:0] cfg_sel = 2'b01;

   // register index fields, same bit numbers in dstaddr and mi_addr
   localparam int cfg_idx_lsb = 3;
   localparam int cfg_idx_msb = 4;
   localparam int cfg_regs    = 4;
   localparam int mmu_idx_lsb = 3;
   localparam int mmu_idx_msb = 6;
   localparam int mmu_entries = 16;

   // register interface types
   typedef logic [14:0] mi_addr_t;
   typedef logic [63:0] mi_data_t;

   // what the node does with an accepted packet
   typedef enum logic [1:0] {
      kind_none,
      kind_reg_write,
      kind_reg_read,
      kind_forward
   } access_kind_e;

   // which register space a packet hits
   typedef enum logic [1:0] {
      space_none,
      space_cfg,
      space_mmu
   } space_e;

endpackage

// File: verilog/ecfg_regs.sv
`timescale 1ns/1ps

module ecfg_regs
   import ecfg_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     mi_en,
   input  logic     mi_we,
   input  mi_addr_t mi_addr,
   input  mi_data_t mi_din,
   output mi_data_t dout
);

   // configuration bank
   mi_data_t   regs [cfg_regs];
   logic [1:0] idx;
   logic       wr;
   logic       rd;

   // register index from the low address bits
   assign idx = mi_addr[cfg_idx_msb:cfg_idx_lsb];

   // write and read strobes
   assign wr = mi_en & mi_we;
   assign rd = mi_en & ~mi_we;

   // writes land at the edge of the accepted cycle
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int i = 0; i < cfg_regs; i++)
         begin
            regs[i] <= '0;
         end
      end
      else if (wr)
      begin
         regs[idx] <= mi_din;
      end
   end

   // combinational readback
   // zero when not read so the top can OR the spaces
   always_comb
   begin
      if (rd)
      begin
         dout = regs[idx];
      end
      else
      begin
         dout = '0;
      end
   end

endmodule

// File: verilog/ecfg_response.sv
`timescale 1ns/1ps

module ecfg_response
   import ecfg_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  access_kind_e kind,
   input  logic         write,
   input  logic [1:0]   datamode,
   input  logic [3:0]   ctrlmode,
   input  logic [31:0]  dstaddr,
   input  logic [31:0]  data,
   input  logic [31:0]  srcaddr,
   input  mi_data_t     mi_dout,
   input  logic         wait_in,
   output logic         access_out,
   output packet_t      packet_out
);

   logic        is_read;
   logic        is_fwd;
   logic        write_q;
   logic [1:0]  datamode_q;
   logic [3:0]  ctrlmode_q;
   logic [31:0] dstaddr_q;
   logic [31:0] data_q;
   logic [31:0] srcaddr_q;

   assign is_read = (kind == kind_reg_read);
   assign is_fwd  = (kind == kind_forward);

   // output valid, held while stalled
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         access_out <= 1'b0;
      end
      else if (!wait_in)
      begin
         access_out <= is_read | is_fwd;
      end
   end

   // outgoing fields, only loaded when a packet goes out
   always_ff @(posedge clk)
   begin
      if (!wait_in && (is_read || is_fwd))
      begin
         // read response goes back to the requester
         write_q    <= is_read ? 1'b1 : write;
         datamode_q <= datamode;
         ctrlmode_q <= ctrlmode;
         dstaddr_q  <= is_read ? srcaddr : dstaddr;
         data_q     <= is_read ? mi_dout[31:0] : data;
         srcaddr_q  <= is_read ? mi_dout[63:32] : srcaddr;
      end
   end

   // pack registered fields
   always_comb
   begin
      packet_out                            = '0;
      packet_out[write_bit]                 = write_q;
      packet_out[datamode_msb:datamode_lsb] = datamode_q;
      packet_out[ctrlmode_msb:ctrlmode_lsb] = ctrlmode_q;
      packet_out[rsvd_bit]                  = 1'b0;
      packet_out[dstaddr_msb:dstaddr_lsb]   = dstaddr_q;
      packet_out[data_msb:data_lsb]         = data_q;
      packet_out[srcaddr_msb:srcaddr_lsb]   = srcaddr_q;
   end

endmodule

// File: verilog/emmu_table.sv
`timescale 1ns/1ps

module emmu_table
   import ecfg_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     mi_en,
   input  logic     mi_we,
   input  mi_addr_t mi_addr,
   input  mi_data_t mi_din,
   output mi_data_t dout
);

   // translation entries for the node address window
   mi_data_t   table_q [mmu_entries];
   logic [3:0] idx;
   logic       wr;
   logic       rd;

   // entry select
   assign idx = mi_addr[mmu_idx_msb:mmu_idx_lsb];

   assign wr = mi_en & mi_we;
   assign rd = mi_en & ~mi_we;

   // entry update, all entries invalid (zero) after reset
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int i = 0; i < mmu_entries; i++)
         begin
            table_q[i] <= '0;
         end
      end
      else if (wr)
      begin
         table_q[idx] <= mi_din;
      end
   end

   // read in the same cycle, zero otherwise
   always_comb
   begin
      dout = '0;
      if (rd)
      begin
         dout = table_q[idx];
      end
   end

endmodule
